// ==== axis_pkt.f ====
hw/axis_pkt_pkg.sv
hw/axis_csum_check.sv
hw/axis_fifo.sv
hw/axis_frame_stats.sv
hw/axis_pkt_top.sv
test/axis_pkt_chk.sv
test/axis_pkt_tb.sv

// ==== hw/axis_csum_check.sv ====
`default_nettype none

module axis_csum_check
  import axis_pkt_pkg::*;
(
  input  wire        clk,
  input  wire        rst,

  input  pkt_beat_t  s_beat,
  input  wire        s_valid,
  output logic       s_ready,

  output pkt_beat_t  m_beat,
  output logic       m_valid,
  input  wire        m_ready
);

  logic [DATA_WIDTH-1:0] csum_reg; // XOR of the bytes seen so far in this frame.
  logic [DATA_WIDTH-1:0] csum_next;
  logic                  accept;
  logic                  csum_bad;

  // The slice can take a new beat when it is empty or draining this cycle.
  assign s_ready = !m_valid || m_ready;
  assign accept = s_valid && s_ready;

  // Last byte carries the checksum of everything before it.
  assign csum_bad = s_beat.data != csum_reg;

  always_comb begin
    csum_next = csum_reg;
    if (accept) begin
      if (s_beat.last) begin
        csum_next = '0; // Next frame starts fresh.
      end else begin
        csum_next = csum_reg ^ s_beat.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      csum_reg <= '0;
      m_valid  <= 1'b0;
    end else begin
      csum_reg <= csum_next;
      if (accept) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  // Payload register, loaded only on a transfer into the slice.
  always_ff @(posedge clk) begin
    if (accept) begin
      m_beat.data <= s_beat.data;
      m_beat.last <= s_beat.last;
      m_beat.user <= s_beat.last && csum_bad;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axis_fifo.sv ====
`default_nettype none

module axis_fifo
  import axis_pkt_pkg::*;
(
  input  wire        clk,
  input  wire        rst,

  input  pkt_beat_t  s_beat,
  input  wire        s_valid,
  output logic       s_ready,

  output pkt_beat_t  m_beat,
  output logic       m_valid,
  input  wire        m_ready,

  output logic       status_overflow,
  output logic       status_bad_frame,
  output logic       status_good_frame
);

  // Pointers carry one extra bit to tell full from empty.
  logic [FIFO_ADDR_WIDTH:0] wr_ptr_reg;     // End of committed frames.
  logic [FIFO_ADDR_WIDTH:0] wr_ptr_next;
  logic [FIFO_ADDR_WIDTH:0] wr_ptr_cur_reg; // End of the frame being written.
  logic [FIFO_ADDR_WIDTH:0] wr_ptr_cur_next;
  logic [FIFO_ADDR_WIDTH:0] rd_ptr_reg;
  logic [FIFO_ADDR_WIDTH:0] rd_ptr_next;

  pkt_beat_t mem [FIFO_DEPTH];

  pkt_beat_t mem_rd_data_reg;
  logic      mem_rd_valid_reg;
  logic      mem_rd_valid_next;
  logic      m_valid_next;

  logic full_cur;
  logic full_wr;
  logic empty;
  logic write;
  logic read;
  logic store_output;

  logic drop_frame_reg;
  logic drop_frame_next;
  logic overflow_next;
  logic bad_frame_next;
  logic good_frame_next;

  // Partial frame has caught up with the read side.
  assign full_cur = (wr_ptr_cur_reg[FIFO_ADDR_WIDTH] != rd_ptr_reg[FIFO_ADDR_WIDTH]) &&
                    (wr_ptr_cur_reg[FIFO_ADDR_WIDTH-1:0] == rd_ptr_reg[FIFO_ADDR_WIDTH-1:0]);
  // Partial frame alone fills the whole memory, so it can never fit.
  assign full_wr = (wr_ptr_reg[FIFO_ADDR_WIDTH] != wr_ptr_cur_reg[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr_reg[FIFO_ADDR_WIDTH-1:0] == wr_ptr_cur_reg[FIFO_ADDR_WIDTH-1:0]);
  assign empty = wr_ptr_reg == rd_ptr_reg;

  assign s_ready = !full_cur || full_wr || drop_frame_reg;

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame_reg;
    overflow_next   = 1'b0;
    bad_frame_next  = 1'b0;
    good_frame_next = 1'b0;
    wr_ptr_next     = wr_ptr_reg;
    wr_ptr_cur_next = wr_ptr_cur_reg;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame_reg) begin
        drop_frame_next = 1'b1; // Swallow the rest of an oversized frame.
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr_reg;
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur_reg + 1'b1;
        if (s_beat.last) begin
          if (s_beat.user) begin
            wr_ptr_cur_next = wr_ptr_reg; // Rewind over the bad frame.
            bad_frame_next  = 1'b1;
          end else begin
            wr_ptr_next     = wr_ptr_cur_reg + 1'b1;
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_reg        <= '0;
      wr_ptr_cur_reg    <= '0;
      drop_frame_reg    <= 1'b0;
      status_overflow   <= 1'b0;
      status_bad_frame  <= 1'b0;
      status_good_frame <= 1'b0;
    end else begin
      wr_ptr_reg        <= wr_ptr_next;
      wr_ptr_cur_reg    <= wr_ptr_cur_next;
      drop_frame_reg    <= drop_frame_next;
      status_overflow   <= overflow_next;
      status_bad_frame  <= bad_frame_next;
      status_good_frame <= good_frame_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur_reg[FIFO_ADDR_WIDTH-1:0]] <= s_beat;
    end
  end

  // Read side, a memory read register followed by the output register.
  assign store_output = m_ready || !m_valid;

  always_comb begin
    read              = 1'b0;
    rd_ptr_next       = rd_ptr_reg;
    mem_rd_valid_next = mem_rd_valid_reg;
    if (store_output || !mem_rd_valid_reg) begin
      if (!empty) begin
        read              = 1'b1;
        mem_rd_valid_next = 1'b1;
        rd_ptr_next       = rd_ptr_reg + 1'b1;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  always_comb begin
    m_valid_next = m_valid;
    if (store_output) begin
      m_valid_next = mem_rd_valid_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_reg       <= '0;
      mem_rd_valid_reg <= 1'b0;
      m_valid          <= 1'b0;
    end else begin
      rd_ptr_reg       <= rd_ptr_next;
      mem_rd_valid_reg <= mem_rd_valid_next;
      m_valid          <= m_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_data_reg <= mem[rd_ptr_reg[FIFO_ADDR_WIDTH-1:0]];
    end
    if (store_output) begin
      m_beat <= mem_rd_data_reg;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axis_frame_stats.sv ====
`default_nettype none

module axis_frame_stats
  import axis_pkt_pkg::*;
(
  input  wire           clk,
  input  wire           rst,

  input  wire           status_good_frame,
  input  wire           status_bad_frame,
  input  wire           status_overflow,

  output frame_stats_t  stats
);

  // Counters hold at all ones instead of wrapping.
  function automatic logic [CNT_WIDTH-1:0] sat_inc(input logic [CNT_WIDTH-1:0] cnt);
    logic [CNT_WIDTH-1:0] result;
    result = cnt;
    if (cnt != {CNT_WIDTH{1'b1}}) begin
      result = cnt + 1'b1;
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      stats <= '0;
    end else begin
      if (status_good_frame) begin
        stats.good_frames <= sat_inc(stats.good_frames);
      end
      if (status_bad_frame) begin
        stats.bad_frames <= sat_inc(stats.bad_frames);
      end
      if (status_overflow) begin
        stats.overflow_frames <= sat_inc(stats.overflow_frames);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/axis_pkt_pkg.sv ====
`default_nettype none

package axis_pkt_pkg;

  // Stream payload width, one byte per beat.
  localparam int DATA_WIDTH = 8;

  localparam int FIFO_ADDR_WIDTH = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_ADDR_WIDTH; // Also the longest frame that passes.

  localparam int CNT_WIDTH = 16;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
    logic                  user; // Bad frame flag, valid on the last beat.
  } pkt_beat_t;

  typedef struct packed {
    logic [CNT_WIDTH-1:0] good_frames;
    logic [CNT_WIDTH-1:0] bad_frames;
    logic [CNT_WIDTH-1:0] overflow_frames;
  } frame_stats_t;

endpackage

`default_nettype wire

// ==== hw/axis_pkt_top.sv ====
`default_nettype none

module axis_pkt_top
  import axis_pkt_pkg::*;
(
  input  wire           clk,
  input  wire           rst,

  input  pkt_beat_t     s_beat,
  input  wire           s_valid,
  output logic          s_ready,

  output pkt_beat_t     m_beat,
  output logic          m_valid,
  input  wire           m_ready,

  output frame_stats_t  stats
);

  pkt_beat_t csum_beat; // Checked stream into the frame FIFO.
  logic      csum_valid;
  logic      csum_ready;

  logic      status_overflow;
  logic      status_bad_frame;
  logic      status_good_frame;

  axis_csum_check axis_csum_check_i (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (csum_beat),
    .m_valid (csum_valid),
    .m_ready (csum_ready)
  );

  axis_fifo axis_fifo_i (
    .clk               (clk),
    .rst               (rst),
    .s_beat            (csum_beat),
    .s_valid           (csum_valid),
    .s_ready           (csum_ready),
    .m_beat            (m_beat),
    .m_valid           (m_valid),
    .m_ready           (m_ready),
    .status_overflow   (status_overflow),
    .status_bad_frame  (status_bad_frame),
    .status_good_frame (status_good_frame)
  );

  axis_frame_stats axis_frame_stats_i (
    .clk               (clk),
    .rst               (rst),
    .status_good_frame (status_good_frame),
    .status_bad_frame  (status_bad_frame),
    .status_overflow   (status_overflow),
    .stats             (stats)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module axis_pkt_tb -f axis_pkt.f -o axis_pkt_sim \
  || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/axis_pkt_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== test/axis_pkt_chk.sv ====
`default_nettype none

module axis_pkt_chk
  import axis_pkt_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  pkt_beat_t  link_beat,
  input  wire        link_valid,
  input  wire        link_ready,
  input  pkt_beat_t  m_beat,
  input  wire        m_valid,
  input  wire        m_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Link between the checksum stage and the frame FIFO.
  link_hold: assert property (@(posedge clk) disable iff (rst)
    link_valid && !link_ready |=> link_valid && $stable(link_beat))
    else $error("Checksum stage beat dropped or changed while stalled");

  output_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("Output beat dropped or changed while stalled");

  reset_quiet: assert property (@(posedge clk) rst |=> !link_valid && !m_valid)
    else $error("Valid asserted during reset");

endmodule

bind axis_pkt_top axis_pkt_chk axis_pkt_chk_i (
  .clk        (clk),
  .rst        (rst),
  .link_beat  (csum_beat),
  .link_valid (csum_valid),
  .link_ready (csum_ready),
  .m_beat     (m_beat),
  .m_valid    (m_valid),
  .m_ready    (m_ready)
);

`default_nettype wire

// ==== test/axis_pkt_tb.sv ====
`default_nettype none

module axis_pkt_tb
  import axis_pkt_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 20;
  localparam int RAND_SEED   = 35;
  localparam int NUM_FRAMES  = 300;
  localparam int MAX_LEN     = 24;
  localparam int DRAIN_LIMIT = 4000; // Cycles for the output and counters to settle.
  localparam int WATCHDOG_NS = NUM_FRAMES * MAX_LEN * 8 * CLK_PERIOD;

  logic         clk = 1'b0;
  logic         rst;
  pkt_beat_t    s_beat;
  logic         s_valid;
  logic         s_ready;
  pkt_beat_t    m_beat;
  logic         m_valid;
  logic         m_ready;
  frame_stats_t stats;

  logic [DATA_WIDTH-1:0] frame_bytes[$];
  logic [DATA_WIDTH-1:0] exp_data[$]; // Bytes of good frames still to come out.
  logic                  exp_last[$];

  int errors;
  int beats_checked;
  int exp_good;
  int exp_bad;
  int exp_overflow;

  axis_pkt_top axis_pkt_top_i (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .stats   (stats)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout at %0t, the run did not complete", $time);
    $display("TEST FAIL");
    $finish;
  end

  // Random frame, mostly short, some oversized, a quarter with a wrong checksum.
  task automatic build_frame();
    int                    len;
    int                    pick;
    int                    i;
    logic [DATA_WIDTH-1:0] xsum;
    logic [DATA_WIDTH-1:0] b;
    frame_bytes.delete();
    pick = int'($urandom_range(0, 7));
    if (pick < 2) begin
      len = int'($urandom_range(FIFO_DEPTH + 1, MAX_LEN));
    end else if (pick == 2) begin
      len = 1;
    end else begin
      len = int'($urandom_range(2, FIFO_DEPTH));
    end
    xsum = '0;
    for (i = 1; i < len; i++) begin
      b = DATA_WIDTH'($urandom_range(0, 255));
      frame_bytes.push_back(b);
      xsum = xsum ^ b;
    end
    if ($urandom_range(0, 3) != 0) begin
      frame_bytes.push_back(xsum);
    end else begin
      frame_bytes.push_back(xsum ^ DATA_WIDTH'($urandom_range(1, 255)));
    end
  endtask

  task automatic model_frame();
    logic [DATA_WIDTH-1:0] running;
    int                    last_idx;
    int                    i;
    last_idx = frame_bytes.size() - 1;
    running = '0;
    for (i = 0; i < last_idx; i++) begin
      running = running ^ frame_bytes[i];
    end
    if (frame_bytes.size() > FIFO_DEPTH) begin
      exp_overflow++;
    end else if (frame_bytes[last_idx] != running) begin
      exp_bad++;
    end else begin
      exp_good++;
      for (i = 0; i <= last_idx; i++) begin
        exp_data.push_back(frame_bytes[i]);
        exp_last.push_back(i == last_idx);
      end
    end
  endtask

  task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
    int idle;
    idle = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 4)) : 0;
    repeat (idle) begin
      @(negedge clk);
      s_valid = 1'b0;
    end
    @(negedge clk);
    s_beat.data = data;
    s_beat.last = last;
    s_beat.user = 1'b0;
    s_valid     = 1'b1;
    @(posedge clk);
    while (!s_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic send_all_frames();
    int f;
    int i;
    for (f = 0; f < NUM_FRAMES; f++) begin
      build_frame();
      model_frame();
      for (i = 0; i < frame_bytes.size(); i++) begin
        send_beat(frame_bytes[i], i == frame_bytes.size() - 1);
      end
    end
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  // Mostly random ready with an occasional long stall.
  task automatic drive_ready();
    int unsigned stall;
    forever begin
      @(negedge clk);
      if ($urandom_range(0, 63) == 0) begin
        stall = $urandom_range(8, 40);
        m_ready = 1'b0;
        repeat (stall - 1) @(negedge clk);
      end else begin
        m_ready = ($urandom_range(0, 3) != 0);
      end
    end
  endtask

  task automatic check_output_beat();
    logic [DATA_WIDTH-1:0] exp_d;
    logic                  exp_l;
    if (exp_data.size() == 0) begin
      $display("Unexpected output beat at %0t with data %02h, no good frame is pending",
               $time, m_beat.data);
      errors++;
    end else begin
      exp_d = exp_data.pop_front();
      exp_l = exp_last.pop_front();
      if (m_beat.data !== exp_d) begin
        $display("Mismatch at %0t: m_beat.data expected %02h got %02h", $time, exp_d, m_beat.data);
        errors++;
      end
      if (m_beat.last !== exp_l) begin
        $display("Mismatch at %0t: m_beat.last expected %0b got %0b", $time, exp_l, m_beat.last);
        errors++;
      end
      if (m_beat.user !== 1'b0) begin
        $display("Mismatch at %0t: m_beat.user expected 0 got %0b", $time, m_beat.user);
        errors++;
      end
      beats_checked++;
    end
  endtask

  task automatic watch_output();
    forever begin
      @(posedge clk);
      if (m_valid && m_ready) begin
        check_output_beat();
      end
    end
  endtask

  task automatic check_after_reset();
    if (m_valid !== 1'b0) begin
      $display("m_valid is not low after reset");
      errors++;
    end
    if (stats !== '0) begin
      $display("Frame counters do not read zero after reset");
      errors++;
    end
  endtask

  // Each frame ends in exactly one status pulse.
  function automatic int counted_frames();
    return int'(stats.good_frames) + int'(stats.bad_frames) + int'(stats.overflow_frames);
  endfunction

  task automatic wait_for_drain();
    int cycles;
    int counted;
    cycles = 0;
    while (exp_data.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_data.size() != 0) begin
      $display("Output stopped at %0t with %0d expected beats never seen",
               $time, exp_data.size());
      errors++;
    end
    cycles = 0;
    counted = counted_frames();
    while (counted != NUM_FRAMES && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
      counted = counted_frames();
    end
    if (counted != NUM_FRAMES) begin
      $display("Frame counters stopped at %0t with %0d of %0d frames counted",
               $time, counted, NUM_FRAMES);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_WIDTH-1:0] got,
                             input int expected);
    if (got !== CNT_WIDTH'(expected)) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, got);
      errors++;
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst           = 1'b1;
    s_valid       = 1'b0;
    s_beat        = '0;
    m_ready       = 1'b0;
    errors        = 0;
    beats_checked = 0;
    exp_good      = 0;
    exp_bad       = 0;
    exp_overflow  = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_after_reset();
    fork
      drive_ready();
      watch_output();
      send_all_frames();
    join_any
    wait_for_drain();
    check_count("stats.good_frames", stats.good_frames, exp_good);
    check_count("stats.bad_frames", stats.bad_frames, exp_bad);
    check_count("stats.overflow_frames", stats.overflow_frames, exp_overflow);
    $display("Errors: %0d, beats checked: %0d, frames good %0d bad %0d overflow %0d",
             errors, beats_checked, exp_good, exp_bad, exp_overflow);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
